/* source/x86_opnd_pkg.sv */
package x86_opnd_pkg;

  // Unescaped instruction bytes, opcode byte in bits 7:0
  localparam int INSTR_W = 72;

  // Operand encodings of the instruction
  localparam logic [3:0] OPND_ENC_NONE                = 4'd0;
  localparam logic [3:0] OPND_ENC_REG                 = 4'd1;
  localparam logic [3:0] OPND_ENC_IMM                 = 4'd2;
  localparam logic [3:0] OPND_ENC_REG_IMM             = 4'd3;
  localparam logic [3:0] OPND_ENC_EAX_IMM             = 4'd4;
  localparam logic [3:0] OPND_ENC_EAX_REG             = 4'd5;
  localparam logic [3:0] OPND_ENC_MODREGRM_RM         = 4'd6;
  localparam logic [3:0] OPND_ENC_MODREGRM_RM_IMM     = 4'd7;
  localparam logic [3:0] OPND_ENC_MODREGRM_RM_REG     = 4'd8;
  localparam logic [3:0] OPND_ENC_MODREGRM_RM_REG_IMM = 4'd9;
  localparam logic [3:0] OPND_ENC_MODREGRM_RM_REG_CL  = 4'd10;
  localparam logic [3:0] OPND_ENC_MODREGRM_REG_RM     = 4'd11;
  localparam logic [3:0] OPND_ENC_MODREGRM_REG_RM_IMM = 4'd12;
  // Displacement only, no ModR/M byte
  localparam logic [3:0] OPND_ENC_DISP                = 4'd13;

  // Command codes
  localparam logic [5:0] CMD_MOV  = 6'd0;
  localparam logic [5:0] CMD_ADD  = 6'd1;
  // String commands
  localparam logic [5:0] CMD_MOVS = 6'd20;
  localparam logic [5:0] CMD_CMPS = 6'd21;
  localparam logic [5:0] CMD_SCAS = 6'd22;
  localparam logic [5:0] CMD_STOS = 6'd23;
  localparam logic [5:0] CMD_LODS = 6'd24;

  // General registers in x86 encoding order
  localparam logic [2:0] REG_EAX = 3'd0;
  localparam logic [2:0] REG_ECX = 3'd1;
  localparam logic [2:0] REG_EDX = 3'd2;
  localparam logic [2:0] REG_EBX = 3'd3;
  localparam logic [2:0] REG_ESP = 3'd4;
  localparam logic [2:0] REG_EBP = 3'd5;
  localparam logic [2:0] REG_ESI = 3'd6;
  localparam logic [2:0] REG_EDI = 3'd7;

  // Destination kinds, one-hot
  // Bit 0 register, bit 1 memory
  localparam logic [1:0] OPND_DEST_NONE = 2'b00;
  localparam logic [1:0] OPND_DEST_REG  = 2'b01;
  localparam logic [1:0] OPND_DEST_MEM  = 2'b10;

  // Byte after ModR/M
  // Either a SIB byte or the low byte of a displacement
  typedef union packed {
    struct packed {
      logic [1:0] scale;
      logic [2:0] index;
      logic [2:0] base;
    } sib;
    logic [7:0] disp8;
  } instr_byte2_u;

endpackage

/* source/gpr_file.sv */
module gpr_file (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_en,
  input  logic [2:0]  wr_sel,
  input  logic [31:0] wr_data,
  input  logic [2:0]  rd_sel0,
  input  logic [2:0]  rd_sel1,
  input  logic [2:0]  rd_sel2,
  input  logic [2:0]  rd_sel3,
  output logic [31:0] rd_data0,
  output logic [31:0] rd_data1,
  output logic [31:0] rd_data2,
  output logic [31:0] rd_data3
);

  // EAX through EDI, indexed by register number
  logic [31:0] regs [8];

  // Architectural state is zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // Reads are combinational and see the old value during a write
  // Port 0 operand#0, port 1 operand#1
  assign rd_data0 = regs[rd_sel0];
  assign rd_data1 = regs[rd_sel1];
  // Port 2 address base, port 3 address index
  assign rd_data2 = regs[rd_sel2];
  assign rd_data3 = regs[rd_sel3];

  // A write with an unknown selector would corrupt an unknown register
  a_wr_sel_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_sel)
  ) else $error("gpr_file: write with unknown wr_sel");

endmodule

/* source/modrm_sib_decode.sv */
module modrm_sib_decode (
  input  logic [x86_opnd_pkg::INSTR_W-1:0] unescaped_instr,
  input  logic [3:0]                       opnd_form,
  input  logic                             prefix_address_16bit,
  output logic                             has_modrm,
  output logic                             has_sib,
  output logic                             has_disp,
  output logic                             disp_1byte,
  output logic [31:0]                      disp_value
);

  logic [15:0]                     form_1hot;
  logic [7:0]                      modrm;
  logic [1:0]                      modrm_mod;
  logic [2:0]                      modrm_rm;
  x86_opnd_pkg::instr_byte2_u      byte2;
  logic                            disp_only_form;
  logic                            disp_4byte;
  logic [7:0]                      disp8_byte;
  logic [31:0]                     disp32_word;

  assign form_1hot = 16'd1 << opnd_form;

  // Every ModR/M form, either direction, with or without immediate
  assign has_modrm = form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM] ||
                     form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_IMM] ||
                     form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG] ||
                     form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG_IMM] ||
                     form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG_CL] ||
                     form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_REG_RM] ||
                     form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_REG_RM_IMM];

  // ModR/M follows the opcode byte
  assign modrm     = unescaped_instr[15:8];
  assign modrm_mod = modrm[7:6];
  assign modrm_rm  = modrm[2:0];
  assign byte2     = unescaped_instr[23:16];

  // SIB only in 32-bit addressing, memory mode, rm 100
  assign has_sib = has_modrm &&
                   !prefix_address_16bit &&
                   modrm_mod != 2'b11 &&
                   modrm_rm == 3'b100;

  assign disp_only_form = form_1hot[x86_opnd_pkg::OPND_ENC_DISP];

  // mod 01 carries a single signed byte
  assign disp_1byte = has_modrm && modrm_mod == 2'b01;

  // disp32 cases
  // mod 10, bare disp32 (mod 00 rm 101), SIB with no base under mod 00
  assign disp_4byte = (has_modrm &&
                       (modrm_mod == 2'b10 ||
                        (modrm_mod == 2'b00 && modrm_rm == 3'b101) ||
                        (has_sib && modrm_mod == 2'b00 && byte2.sib.base == 3'b101))) ||
                      disp_only_form;

  assign has_disp = disp_1byte || disp_4byte;

  // Displacement starts one byte later when a SIB byte sits in between
  assign disp8_byte = has_sib ? unescaped_instr[31:24] : byte2.disp8;

  // Little-endian, lowest byte first
  assign disp32_word = disp_only_form ? unescaped_instr[39:8]  :
                       has_sib        ? unescaped_instr[55:24] :
                                        unescaped_instr[47:16];

  always_comb begin
    if (disp_1byte) begin
      // Sign extend disp8
      disp_value = {{24{disp8_byte[7]}}, disp8_byte};
    end else if (disp_4byte) begin
      disp_value = disp32_word;
    end else begin
      disp_value = 32'd0;
    end
  end

endmodule

/* source/agu.sv */
module agu (
  input  logic [1:0]  scale,
  input  logic [31:0] index,
  input  logic [31:0] base,
  input  logic [31:0] disp,
  input  logic        addr16,
  output logic [31:0] address
);

  logic [31:0] scaled_index;
  logic [31:0] sum;

  // Scale encodes a factor of 1, 2, 4 or 8
  assign scaled_index = index << scale;

  // Wraps modulo 2^32 like the hardware adder
  assign sum = base + scaled_index + disp;

  // Address-size prefix keeps only the low 16 bits
  assign address = addr16 ? {16'd0, sum[15:0]} : sum;

endmodule

/* source/decode_opnds.sv */
module decode_opnds (
  input  logic [x86_opnd_pkg::INSTR_W-1:0] unescaped_instr,
  input  logic [5:0]                       opc,
  input  logic [3:0]                       opnd_form,
  input  logic                             prefix_address_16bit,
  input  logic                             has_sib,
  input  logic                             has_disp,
  input  logic [31:0]                      disp_value,
  output logic [2:0]                       reg_sel0,
  output logic [2:0]                       reg_sel1,
  output logic [2:0]                       reg_sel2,
  output logic [2:0]                       reg_sel3,
  input  logic [31:0]                      reg_val0,
  input  logic [31:0]                      reg_val1,
  input  logic [31:0]                      reg_val2,
  input  logic [31:0]                      reg_val3,
  output logic [31:0]                      opnd0,
  output logic [31:0]                      opnd1,
  output logic [31:0]                      mem_addr,
  output logic                             opnd0_is_mem,
  output logic                             opnd1_is_mem,
  output logic [1:0]                       dest0_kind,
  output logic [1:0]                       dest1_kind,
  output logic [2:0]                       dest0_sel,
  output logic [2:0]                       dest1_sel
);

  logic [15:0]                form_1hot;
  logic [63:0]                opc_1hot;
  logic                       opnd0_modrm_rm;
  logic                       opnd0_modrm_reg;
  logic                       opnd1_modrm_rm;
  logic                       opnd1_modrm_reg;
  logic [7:0]                 modrm;
  logic                       rm_is_reg;
  x86_opnd_pkg::instr_byte2_u byte2;
  logic                       opnd0_is_reg;
  logic                       opnd1_is_reg;
  logic                       modrm_no_base;
  logic                       sib_no_base;
  logic                       sib_no_index;
  logic                       base_used;
  logic [31:0]                eff_base;
  logic [31:0]                eff_index;
  logic [31:0]                eff_disp;

  assign form_1hot = 16'd1 << opnd_form;
  assign opc_1hot  = 64'd1 << opc;

  // R/M is operand#0 (d = 0)
  assign opnd0_modrm_rm = form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM] ||
                          form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_IMM] ||
                          form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG] ||
                          form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG_IMM] ||
                          form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG_CL];
  // REG is operand#0 (d = 1), R/M then goes to operand#1
  assign opnd0_modrm_reg = form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_REG_RM] ||
                           form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_REG_RM_IMM];
  assign opnd1_modrm_rm  = opnd0_modrm_reg;
  assign opnd1_modrm_reg = form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG] ||
                           form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG_IMM] ||
                           form_1hot[x86_opnd_pkg::OPND_ENC_MODREGRM_RM_REG_CL];

  assign modrm     = unescaped_instr[15:8];
  assign rm_is_reg = modrm[7:6] == 2'b11;
  assign byte2     = unescaped_instr[23:16];

  // Register operand#0 sources
  // opcode low bits, rm in register mode, reg field, implicit EAX
  assign opnd0_is_reg = form_1hot[x86_opnd_pkg::OPND_ENC_REG] ||
                        form_1hot[x86_opnd_pkg::OPND_ENC_REG_IMM] ||
                        form_1hot[x86_opnd_pkg::OPND_ENC_EAX_IMM] ||
                        form_1hot[x86_opnd_pkg::OPND_ENC_EAX_REG] ||
                        (opnd0_modrm_rm && rm_is_reg) ||
                        opnd0_modrm_reg;

  assign reg_sel0 =
    (form_1hot[x86_opnd_pkg::OPND_ENC_REG] || form_1hot[x86_opnd_pkg::OPND_ENC_REG_IMM]) ?
      unescaped_instr[2:0] :
    (opnd0_modrm_rm && rm_is_reg) ? modrm[2:0] :
    opnd0_modrm_reg ? modrm[5:3] :
    x86_opnd_pkg::REG_EAX;

  // Register operand#1 sources
  assign opnd1_is_reg = form_1hot[x86_opnd_pkg::OPND_ENC_EAX_REG] ||
                        (opnd1_modrm_rm && rm_is_reg) ||
                        opnd1_modrm_reg;

  assign reg_sel1 = (opnd1_modrm_rm && rm_is_reg) ? modrm[2:0] :
                    opnd1_modrm_reg ? modrm[5:3] :
                    form_1hot[x86_opnd_pkg::OPND_ENC_EAX_REG] ? unescaped_instr[2:0] :
                    3'd0;

  // Memory flags, string commands included
  assign opnd0_is_mem = (opnd0_modrm_rm && !rm_is_reg) ||
                        opc_1hot[x86_opnd_pkg::CMD_MOVS] ||
                        opc_1hot[x86_opnd_pkg::CMD_CMPS] ||
                        opc_1hot[x86_opnd_pkg::CMD_SCAS];
  assign opnd1_is_mem = opc_1hot[x86_opnd_pkg::CMD_MOVS] ||
                        opc_1hot[x86_opnd_pkg::CMD_CMPS] ||
                        opc_1hot[x86_opnd_pkg::CMD_STOS] ||
                        opc_1hot[x86_opnd_pkg::CMD_LODS];

  // Base from SIB, else from rm in memory mode
  assign reg_sel2 = has_sib ? byte2.sib.base :
                    (opnd0_modrm_rm && !rm_is_reg) ? modrm[2:0] : 3'd0;
  assign reg_sel3 = has_sib ? byte2.sib.index : 3'd0;

  // mod 00 rm 101 without SIB is a bare disp32
  assign modrm_no_base = !has_sib && modrm[7:6] == 2'b00 && modrm[2:0] == 3'b101;
  // SIB base 101 under mod 00 drops the base register
  assign sib_no_base   = has_sib && byte2.sib.base == 3'b101 && modrm[7:6] == 2'b00;
  // SIB index 100 means no index
  assign sib_no_index  = has_sib && byte2.sib.index == 3'b100;

  assign base_used = has_sib ? !sib_no_base : (opnd0_modrm_rm && !rm_is_reg && !modrm_no_base);
  assign eff_base  = base_used ? reg_val2 : 32'd0;
  assign eff_index = (has_sib && !sib_no_index) ? reg_val3 : 32'd0;
  assign eff_disp  = has_disp ? disp_value : 32'd0;

  agu u_agu (
    .scale   (has_sib ? byte2.sib.scale : 2'b00),
    .index   (eff_index),
    .base    (eff_base),
    .disp    (eff_disp),
    .addr16  (prefix_address_16bit),
    .address (mem_addr)
  );

  // Memory operands report zero, no memory read here
  assign opnd0 = opnd0_is_reg ? reg_val0 : 32'd0;
  assign opnd1 = opnd1_is_reg ? reg_val1 : 32'd0;

  assign dest0_kind = opnd0_is_reg ? x86_opnd_pkg::OPND_DEST_REG :
                      opnd0_is_mem ? x86_opnd_pkg::OPND_DEST_MEM :
                                     x86_opnd_pkg::OPND_DEST_NONE;
  // Only MOVS writes a second destination
  assign dest1_kind = opc_1hot[x86_opnd_pkg::CMD_MOVS] ? x86_opnd_pkg::OPND_DEST_MEM :
                                                         x86_opnd_pkg::OPND_DEST_NONE;

  assign dest0_sel = dest0_kind[0] ? reg_sel0 : 3'd0;
  assign dest1_sel = dest1_kind[0] ? reg_sel1 : 3'd0;

  // Form and command must agree on what operand#0 is
  always_comb begin
    a_opnd0_kind: assert final (!(opnd0_is_reg && opnd0_is_mem))
      else $error("decode_opnds: operand#0 both register and memory");
  end

endmodule

/* source/opnd_stage.sv */
module opnd_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wr_en,
  input  logic [2:0]                       wr_sel,
  input  logic [31:0]                      wr_data,
  input  logic                             instr_valid,
  input  logic [x86_opnd_pkg::INSTR_W-1:0] unescaped_instr,
  input  logic [5:0]                       opc,
  input  logic [3:0]                       opnd_form,
  input  logic                             prefix_address_16bit,
  output logic                             opnd_valid,
  output logic [31:0]                      opnd0,
  output logic [31:0]                      opnd1,
  output logic [31:0]                      mem_addr,
  output logic                             disp_1byte,
  output logic [31:0]                      disp,
  output logic                             opnd0_is_mem,
  output logic                             opnd1_is_mem,
  output logic [1:0]                       dest0_kind,
  output logic [1:0]                       dest1_kind,
  output logic [2:0]                       dest0_sel,
  output logic [2:0]                       dest1_sel
);

  logic        has_sib;
  logic        has_disp;
  logic        dec_disp_1byte;
  logic [31:0] disp_value;
  logic [2:0]  reg_sel0;
  logic [2:0]  reg_sel1;
  logic [2:0]  reg_sel2;
  logic [2:0]  reg_sel3;
  logic [31:0] reg_val0;
  logic [31:0] reg_val1;
  logic [31:0] reg_val2;
  logic [31:0] reg_val3;
  logic [31:0] dec_opnd0;
  logic [31:0] dec_opnd1;
  logic [31:0] dec_mem_addr;
  logic        dec_opnd0_is_mem;
  logic        dec_opnd1_is_mem;
  logic [1:0]  dec_dest0_kind;
  logic [1:0]  dec_dest1_kind;
  logic [2:0]  dec_dest0_sel;
  logic [2:0]  dec_dest1_sel;

  gpr_file u_gpr_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_sel   (wr_sel),
    .wr_data  (wr_data),
    .rd_sel0  (reg_sel0),
    .rd_sel1  (reg_sel1),
    .rd_sel2  (reg_sel2),
    .rd_sel3  (reg_sel3),
    .rd_data0 (reg_val0),
    .rd_data1 (reg_val1),
    .rd_data2 (reg_val2),
    .rd_data3 (reg_val3)
  );

  modrm_sib_decode u_modrm_sib_decode (
    .unescaped_instr      (unescaped_instr),
    .opnd_form            (opnd_form),
    .prefix_address_16bit (prefix_address_16bit),
    .has_modrm            (),
    .has_sib              (has_sib),
    .has_disp             (has_disp),
    .disp_1byte           (dec_disp_1byte),
    .disp_value           (disp_value)
  );

  decode_opnds u_decode_opnds (
    .unescaped_instr      (unescaped_instr),
    .opc                  (opc),
    .opnd_form            (opnd_form),
    .prefix_address_16bit (prefix_address_16bit),
    .has_sib              (has_sib),
    .has_disp             (has_disp),
    .disp_value           (disp_value),
    .reg_sel0             (reg_sel0),
    .reg_sel1             (reg_sel1),
    .reg_sel2             (reg_sel2),
    .reg_sel3             (reg_sel3),
    .reg_val0             (reg_val0),
    .reg_val1             (reg_val1),
    .reg_val2             (reg_val2),
    .reg_val3             (reg_val3),
    .opnd0                (dec_opnd0),
    .opnd1                (dec_opnd1),
    .mem_addr             (dec_mem_addr),
    .opnd0_is_mem         (dec_opnd0_is_mem),
    .opnd1_is_mem         (dec_opnd1_is_mem),
    .dest0_kind           (dec_dest0_kind),
    .dest1_kind           (dec_dest1_kind),
    .dest0_sel            (dec_dest0_sel),
    .dest1_sel            (dec_dest1_sel)
  );

  // Valid for exactly the cycle after the accepting edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opnd_valid <= 1'b0;
    end else begin
      opnd_valid <= instr_valid;
    end
  end

  // Results hold until the next instruction and are zero out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opnd0        <= 32'd0;
      opnd1        <= 32'd0;
      mem_addr     <= 32'd0;
      disp_1byte   <= 1'b0;
      disp         <= 32'd0;
      opnd0_is_mem <= 1'b0;
      opnd1_is_mem <= 1'b0;
      dest0_kind   <= 2'b00;
      dest1_kind   <= 2'b00;
      dest0_sel    <= 3'd0;
      dest1_sel    <= 3'd0;
    end else if (instr_valid) begin
      opnd0        <= dec_opnd0;
      opnd1        <= dec_opnd1;
      mem_addr     <= dec_mem_addr;
      disp_1byte   <= dec_disp_1byte;
      disp         <= disp_value;
      opnd0_is_mem <= dec_opnd0_is_mem;
      opnd1_is_mem <= dec_opnd1_is_mem;
      dest0_kind   <= dec_dest0_kind;
      dest1_kind   <= dec_dest1_kind;
      dest0_sel    <= dec_dest0_sel;
      dest1_sel    <= dec_dest1_sel;
    end
  end

  // Result due one cycle after each accepted instruction
  a_valid_follows: assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_valid |=> opnd_valid
  ) else $error("opnd_stage: result missing one cycle after instr_valid");

endmodule

/* testbench/tb_opnd_stage.sv */
module tb_opnd_stage;
  timeunit 1ns;
  timeprecision 1ps;

  // One instruction with its optional same-cycle register write and expected results
  typedef struct packed {
    logic [255:0] name;
    logic         wr_en;
    logic [2:0]   wr_sel;
    logic [31:0]  wr_data;
    logic [3:0]   form;
    logic [5:0]   opc;
    logic         prefix;
    logic [71:0]  instr;
    logic [31:0]  opnd0;
    logic [31:0]  opnd1;
    logic [31:0]  addr;
    logic         d1b;
    logic [31:0]  disp;
    logic         m0;
    logic         m1;
    logic [1:0]   k0;
    logic [1:0]   k1;
    logic [2:0]   s0;
    logic [2:0]   s1;
  } instr_rec_t;

  logic        clk;
  logic        rst_n;
  logic        wr_en;
  logic [2:0]  wr_sel;
  logic [31:0] wr_data;
  logic        instr_valid;
  logic [71:0] unescaped_instr;
  logic [5:0]  opc;
  logic [3:0]  opnd_form;
  logic        prefix_address_16bit;
  logic        opnd_valid;
  logic [31:0] opnd0;
  logic [31:0] opnd1;
  logic [31:0] mem_addr;
  logic        disp_1byte;
  logic [31:0] disp;
  logic        opnd0_is_mem;
  logic        opnd1_is_mem;
  logic [1:0]  dest0_kind;
  logic [1:0]  dest1_kind;
  logic [2:0]  dest0_sel;
  logic [2:0]  dest1_sel;

  int         fd;
  int         errors;
  int         timeouts;
  int         checks;
  int         lines;
  // Records of a back-to-back block, in issue order
  instr_rec_t pending[$];

  opnd_stage dut (
    .clk                  (clk),
    .rst_n                (rst_n),
    .wr_en                (wr_en),
    .wr_sel               (wr_sel),
    .wr_data              (wr_data),
    .instr_valid          (instr_valid),
    .unescaped_instr      (unescaped_instr),
    .opc                  (opc),
    .opnd_form            (opnd_form),
    .prefix_address_16bit (prefix_address_16bit),
    .opnd_valid           (opnd_valid),
    .opnd0                (opnd0),
    .opnd1                (opnd1),
    .mem_addr             (mem_addr),
    .disp_1byte           (disp_1byte),
    .disp                 (disp),
    .opnd0_is_mem         (opnd0_is_mem),
    .opnd1_is_mem         (opnd1_is_mem),
    .dest0_kind           (dest0_kind),
    .dest1_kind           (dest1_kind),
    .dest0_sel            (dest0_sel),
    .dest1_sel            (dest1_sel)
  );

  // 8 ns period
  always #4 clk = ~clk;

  task automatic compare_value(input string tname, input string field,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("error: %0s %0s expected %h actual %h", tname, field, exp_val, act_val);
    end
  endtask

  // Outputs before any instruction
  task automatic check_idle_outputs(input string tag);
    compare_value(tag, "opnd_valid", 32'd0, 32'(opnd_valid));
    compare_value(tag, "opnd0", 32'd0, opnd0);
    compare_value(tag, "opnd1", 32'd0, opnd1);
    compare_value(tag, "mem_addr", 32'd0, mem_addr);
    compare_value(tag, "disp_1byte", 32'd0, 32'(disp_1byte));
    compare_value(tag, "disp", 32'd0, disp);
    compare_value(tag, "opnd0_is_mem", 32'd0, 32'(opnd0_is_mem));
    compare_value(tag, "opnd1_is_mem", 32'd0, 32'(opnd1_is_mem));
    compare_value(tag, "dest0_kind", 32'd0, 32'(dest0_kind));
    compare_value(tag, "dest1_kind", 32'd0, 32'(dest1_kind));
    compare_value(tag, "dest0_sel", 32'd0, 32'(dest0_sel));
    compare_value(tag, "dest1_sel", 32'd0, 32'(dest1_sel));
  endtask

  task automatic check_result(input instr_rec_t rec);
    string tname;
    tname = $sformatf("%0s", rec.name);
    compare_value(tname, "opnd0", rec.opnd0, opnd0);
    compare_value(tname, "opnd1", rec.opnd1, opnd1);
    compare_value(tname, "mem_addr", rec.addr, mem_addr);
    compare_value(tname, "disp_1byte", 32'(rec.d1b), 32'(disp_1byte));
    compare_value(tname, "disp", rec.disp, disp);
    compare_value(tname, "opnd0_is_mem", 32'(rec.m0), 32'(opnd0_is_mem));
    compare_value(tname, "opnd1_is_mem", 32'(rec.m1), 32'(opnd1_is_mem));
    compare_value(tname, "dest0_kind", 32'(rec.k0), 32'(dest0_kind));
    compare_value(tname, "dest1_kind", 32'(rec.k1), 32'(dest1_kind));
    compare_value(tname, "dest0_sel", 32'(rec.s0), 32'(dest0_sel));
    compare_value(tname, "dest1_sel", 32'(rec.s1), 32'(dest1_sel));
  endtask

  // Called on a falling edge, strobe held for one cycle
  task automatic write_register(input logic [2:0] sel, input logic [31:0] value);
    wr_en   = 1'b1;
    wr_sel  = sel;
    wr_data = value;
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic drive_instr(input instr_rec_t rec);
    wr_en                = rec.wr_en;
    wr_sel               = rec.wr_sel;
    wr_data              = rec.wr_data;
    instr_valid          = 1'b1;
    unescaped_instr      = rec.instr;
    opc                  = rec.opc;
    opnd_form            = rec.form;
    prefix_address_16bit = rec.prefix;
  endtask

  // Single instruction, result expected within 4 cycles
  task automatic wait_result(input instr_rec_t rec);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 4) begin
      @(posedge clk);
      @(negedge clk);
      instr_valid = 1'b0;
      wr_en       = 1'b0;
      cycles++;
      if (opnd_valid) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      check_result(rec);
    end else begin
      timeouts++;
      $display("timeout: no opnd_valid within 4 cycles for %0s", rec.name);
    end
  endtask

  // One instruction per cycle, each result due exactly one cycle later
  task automatic run_block();
    instr_rec_t rec;
    while (pending.size() > 0) begin
      rec = pending.pop_front();
      drive_instr(rec);
      @(posedge clk);
      @(negedge clk);
      if (!opnd_valid) begin
        errors++;
        $display("block result for %0s came without opnd_valid", rec.name);
      end else begin
        check_result(rec);
      end
    end
    instr_valid = 1'b0;
    wr_en       = 1'b0;
  endtask

  task automatic read_record(input logic has_write, output instr_rec_t rec, output logic ok);
    logic [255:0] v_name;
    logic [31:0]  v_wen;
    logic [31:0]  v_wsel;
    logic [31:0]  v_wdata;
    logic [31:0]  v_form;
    logic [31:0]  v_opc;
    logic [31:0]  v_prefix;
    logic [71:0]  v_instr;
    logic [31:0]  v_o0;
    logic [31:0]  v_o1;
    logic [31:0]  v_addr;
    logic [31:0]  v_d1b;
    logic [31:0]  v_disp;
    logic [31:0]  v_m0;
    logic [31:0]  v_m1;
    logic [31:0]  v_k0;
    logic [31:0]  v_k1;
    logic [31:0]  v_s0;
    logic [31:0]  v_s1;
    int           code;
    int           want;
    v_wen   = 32'd0;
    v_wsel  = 32'd0;
    v_wdata = 32'd0;
    if (has_write) begin
      code = $fscanf(fd, "%s %h %h %h", v_name, v_wen, v_wsel, v_wdata);
      want = 4;
    end else begin
      code = $fscanf(fd, "%s", v_name);
      want = 1;
    end
    code = code + $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          v_form, v_opc, v_prefix, v_instr, v_o0, v_o1, v_addr, v_d1b,
                          v_disp, v_m0, v_m1, v_k0, v_k1, v_s0, v_s1);
    ok           = (code == want + 15);
    rec.name     = v_name;
    rec.wr_en    = v_wen[0];
    rec.wr_sel   = v_wsel[2:0];
    rec.wr_data  = v_wdata;
    rec.form     = v_form[3:0];
    rec.opc      = v_opc[5:0];
    rec.prefix   = v_prefix[0];
    rec.instr    = v_instr;
    rec.opnd0    = v_o0;
    rec.opnd1    = v_o1;
    rec.addr     = v_addr;
    rec.d1b      = v_d1b[0];
    rec.disp     = v_disp;
    rec.m0       = v_m0[0];
    rec.m1       = v_m1[0];
    rec.k0       = v_k0[1:0];
    rec.k1       = v_k1[1:0];
    rec.s0       = v_s0[2:0];
    rec.s1       = v_s1[2:0];
  endtask

  // Line kinds: # comment, W write, I single, B queued, G issue queued block
  task automatic process_file();
    logic [7:0]     kind;
    logic [2047:0]  rest;
    logic [31:0]    v_sel;
    logic [31:0]    v_val;
    instr_rec_t     rec;
    logic           ok;
    logic           done;
    int             code;
    done = 1'b0;
    while (!done && lines < 1000) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        lines++;
        case (kind)
          "#": code = $fgets(rest, fd);
          "W": begin
            code = $fscanf(fd, "%h %h", v_sel, v_val);
            if (code != 2) begin
              errors++;
              $display("malformed register write on data line %0d", lines);
            end else begin
              write_register(v_sel[2:0], v_val);
            end
          end
          "I", "B": begin
            read_record(kind == "B", rec, ok);
            if (!ok) begin
              errors++;
              $display("malformed instruction record on data line %0d", lines);
            end else if (kind == "B") begin
              pending.push_back(rec);
            end else begin
              drive_instr(rec);
              wait_result(rec);
            end
          end
          "G": run_block();
          default: begin
            errors++;
            $display("unknown line kind on data line %0d", lines);
          end
        endcase
      end
    end
    // Leftover block without a G line
    run_block();
  endtask

  initial begin
    clk                  = 1'b0;
    rst_n                = 1'b0;
    wr_en                = 1'b0;
    wr_sel               = 3'd0;
    wr_data              = 32'd0;
    instr_valid          = 1'b0;
    // Nonzero bus during reset must not reach the outputs
    unescaped_instr      = 72'h5A_A5C3_3C96_69F0_0F;
    opc                  = 6'd0;
    opnd_form            = 4'd8;
    prefix_address_16bit = 1'b0;
    errors               = 0;
    timeouts             = 0;
    checks               = 0;
    lines                = 0;

    repeat (5) begin
      @(negedge clk);
      check_idle_outputs("reset");
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_idle_outputs("after_reset");
    end
    unescaped_instr = 72'd0;

    fd = $fopen("testbench/opnd_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open testbench/opnd_testdata.txt");
    end else begin
      process_file();
      $fclose(fd);
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* files.f */
source/x86_opnd_pkg.sv
source/gpr_file.sv
source/modrm_sib_decode.sv
source/agu.sv
source/decode_opnds.sv
source/opnd_stage.sv
testbench/tb_opnd_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the operand stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_opnd_stage \
  -Mdir obj_dir -o sim_opnd_stage

./obj_dir/sim_opnd_stage > sim.log
cat sim.log

if grep -F -q '*** FAILED ***' sim.log; then
  exit 1
fi

/* testbench/opnd_testdata.txt */
# W reg value | I name form opc prefix instr opnd0 opnd1 mem_addr d1b disp m0 m1 k0 k1 s0 s1
# B name wr_en wr_sel wr_data then the I columns | G issues the B block | all numbers hex
W 0 11111111
W 1 00000100
W 2 00002000
W 3 00030000
W 4 00401234
W 5 05000000
W 6 60000000
W 7 00000007
# Register forms
I reg_low_bits 1 01 0 000000000000000042 00002000 00000000 00000000 0 00000000 0 0 1 0 2 0
I eax_reg 5 00 0 000000000000000093 11111111 00030000 00000000 0 00000000 0 0 1 0 0 0
I rm_reg_mod11 8 01 0 00000000000000D701 00000007 00002000 00000000 0 00000000 0 0 1 0 7 0
I reg_rm_mod11 b 00 0 00000000000000CE8B 00000100 60000000 00000000 0 00000000 0 0 1 0 1 0
# ModR/M memory forms
I mem_mod00 6 01 0 0000000000000003FF 00000000 00000000 00030000 0 00000000 1 0 2 0 0 0
I mem_disp8_neg 8 00 0 000000000000F04689 00000000 11111111 5FFFFFF0 1 FFFFFFF0 1 0 2 0 0 0
I mem_disp8_pos 6 01 0 0000000000007F41FF 00000000 00000000 0000017F 1 0000007F 1 0 2 0 0 0
I mem_disp32 8 00 0 000000123456789D89 00000000 00030000 17345678 0 12345678 1 0 2 0 0 0
I mem_disp32_only 6 01 0 0000000040100005FF 00000000 00000000 00401000 0 00401000 1 0 2 0 0 0
# SIB forms
I sib_scale0 6 01 0 0000000000000B04FF 00000000 00000000 00030100 0 00000000 1 0 2 0 0 0
I sib_scale1_d8 6 01 0 0000000000105644FF 00000000 00000000 60004010 1 00000010 1 0 2 0 0 0
I sib_scale2_d32 8 00 0 000000001000B99489 00000000 00002000 0000111C 0 00001000 1 0 2 0 0 0
I sib_scale3 6 01 0 000000000000C804FF 00000000 00000000 11111911 0 00000000 1 0 2 0 0 0
I sib_no_index 6 01 0 0000000000FCA244FF 00000000 00000000 00001FFC 1 FFFFFFFC 1 0 2 0 0 0
I sib_no_base 6 01 0 0000000000407504FF 00000000 00000000 C0000040 0 00000040 1 0 2 0 0 0
I sib_ebp_mod01 6 01 0 0000000000082544FF 00000000 00000000 05000008 1 00000008 1 0 2 0 0 0
# 16-bit address prefix
I addr16_no_sib 6 01 1 0000000000000B04FF 00000000 00000000 00001234 0 00000000 1 0 2 0 0 0
I addr16_disp8 6 01 1 0000000000003446FF 00000000 00000000 00000034 1 00000034 1 0 2 0 0 0
I addr16_wrap 6 01 1 0000000000FFF083FF 00000000 00000000 0000FFF0 0 0000FFF0 1 0 2 0 0 0
I disp_only d 00 0 0000000000C0FFEEA1 00000000 00000000 00C0FFEE 0 00C0FFEE 0 0 0 0 0 0
# String commands
I str_movs 0 14 0 0000000000000000A5 00000000 00000000 00000000 0 00000000 1 1 2 2 0 0
I str_cmps 0 15 0 0000000000000000A7 00000000 00000000 00000000 0 00000000 1 1 2 0 0 0
I str_scas 0 16 0 0000000000000000AF 00000000 00000000 00000000 0 00000000 1 0 2 0 0 0
I str_stos 0 17 0 0000000000000000AB 00000000 00000000 00000000 0 00000000 0 1 0 0 0 0
I str_lods 0 18 0 0000000000000000AD 00000000 00000000 00000000 0 00000000 0 1 0 0 0 0
# Back to back, EDI written in the cycle of the second instruction
B pipe_rm_edx 0 0 00000000 8 01 0 00000000000000FA01 00002000 00000007 00000000 0 00000000 0 0 1 0 2 0
B pipe_wr_same 1 7 ABCD0000 1 01 0 000000000000000047 00000007 00000000 00000000 0 00000000 0 0 1 0 7 0
B pipe_wr_seen 0 0 00000000 5 00 0 000000000000000097 11111111 ABCD0000 00000000 0 00000000 0 0 1 0 0 0
G
